// ==== hdl/xbi_macros.svh ====
// ======================================================================
// Sizing constants of the user-to-crossbar interface
// Include where widths, VC layout or packet sizes are needed
// ======================================================================

`ifndef XBI_MACROS_SVH
`define XBI_MACROS_SVH

// Buffer geometry
`define XBI_NUM_VC   3
`define XBI_SLOTS    6
`define XBI_WORD_W   16
`define XBI_ADR_W    10
`define XBI_OFS_W    6

// VC regions with packet sizes that keep slot bases to adders
`define XBI_VC0_BASE 0
`define XBI_VC1_BASE 128
`define XBI_VC2_BASE 512
`define XBI_VC0_PKT  12
`define XBI_VC1_PKT  64
`define XBI_VC2_PKT  64

// Word of a packet that carries the destination
`define XBI_DST_OFS  1

`endif

// ==== hdl/xbi_port_pkg.sv ====
// ======================================================================
// Types seen on the external user and crossbar ports
// Imported by the writer, the reader and the top level
// ======================================================================

`include "xbi_macros.svh"

package xbi_port_pkg;

  // Virtual channel number
  typedef enum logic [1:0] {
    VC0 = 2'd0,
    VC1 = 2'd1,
    VC2 = 2'd2
  } vc_e;

  // One bit per VC for the full and empty flags
  typedef logic [`XBI_NUM_VC-1:0] vc_mask_t;

  // One word written by the user agent
  typedef struct packed {
    vc_e                     vc;
    logic [`XBI_OFS_W-1:0]   offset;
    logic                    eop;
    logic [`XBI_WORD_W-1:0]  data;
  } usr_word_t;

  // One dequeue issued by the crossbar agent
  typedef struct packed {
    vc_e                     vc;
    logic [`XBI_OFS_W-1:0]   offset;
    logic                    eop;
  } xbar_deq_t;

  // Destination word of a head packet pushed ahead of dequeue
  typedef struct packed {
    logic                    valid;
    vc_e                     vc;
    logic [`XBI_WORD_W-1:0]  dst;
  } peek_t;

endpackage

// ==== hdl/xbi_mem_pkg.sv ====
// ======================================================================
// Types for access to the shared packet buffer and its pointers
// Imported by the arbiter, slot pointers and both buffer peers
// ======================================================================

`include "xbi_macros.svh"

package xbi_mem_pkg;

  typedef logic [`XBI_ADR_W-1:0] adr_t;

  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_op_e;

  typedef struct packed {
    mem_op_e                 op;
    adr_t                    adr;
    logic [`XBI_WORD_W-1:0]  wdata;
  } mem_req_t;

  // Slot base address of every VC
  typedef adr_t [`XBI_NUM_VC-1:0] vc_bases_t;

endpackage

// ==== hdl/xbi_slot_ptr.sv ====
// ======================================================================
// Ring of fixed-size packet slots for one virtual channel
// Tracks write and read slots, reports full, empty and slot bases
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module xbi_slot_ptr
  import xbi_mem_pkg::*;
#(
  parameter adr_t BASE_START  = adr_t'(`XBI_VC0_BASE),
  parameter adr_t PACKET_SIZE = adr_t'(`XBI_VC0_PKT)
) (
  input  logic clk_xbar,
  input  logic rst_xbar,
  input  logic i_wr_advance,
  input  logic i_rd_advance,
  output logic o_full,
  output logic o_empty,
  output adr_t o_wr_base,
  output adr_t o_rd_base
);

  localparam int IDX_W = $clog2(`XBI_SLOTS);
  localparam int CNT_W = $clog2(`XBI_SLOTS + 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`XBI_SLOTS - 1);

  logic [IDX_W-1:0] wr_idx_q;
  logic [IDX_W-1:0] rd_idx_q;
  logic [CNT_W-1:0] pkt_cnt_q;

  // Bases run alongside the indices so no multiplier is needed
  always_ff @(posedge clk_xbar) begin
    if (rst_xbar) begin
      wr_idx_q  <= '0;
      rd_idx_q  <= '0;
      pkt_cnt_q <= '0;
      o_wr_base <= BASE_START;
      o_rd_base <= BASE_START;
    end else begin
      if (i_wr_advance) begin
        wr_idx_q  <= (wr_idx_q == LAST_IDX) ? '0 : wr_idx_q + 1'b1;
        o_wr_base <= (wr_idx_q == LAST_IDX) ? BASE_START : o_wr_base + PACKET_SIZE;
      end
      if (i_rd_advance) begin
        rd_idx_q  <= (rd_idx_q == LAST_IDX) ? '0 : rd_idx_q + 1'b1;
        o_rd_base <= (rd_idx_q == LAST_IDX) ? BASE_START : o_rd_base + PACKET_SIZE;
      end
      // Simultaneous advances leave the count alone
      if (i_wr_advance && !i_rd_advance) begin
        pkt_cnt_q <= pkt_cnt_q + 1'b1;
      end else if (!i_wr_advance && i_rd_advance) begin
        pkt_cnt_q <= pkt_cnt_q - 1'b1;
      end
    end
  end

  assign o_full  = (pkt_cnt_q == CNT_W'(`XBI_SLOTS));
  assign o_empty = (pkt_cnt_q == '0);

endmodule

// ==== hdl/xbi_mem_arbiter.sv ====
// ======================================================================
// Single-port packet buffer shared by the user writer and the reader
// Grants one access per cycle, alternating between peers on conflict
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module xbi_mem_arbiter
  import xbi_mem_pkg::*;
(
  input  logic                   clk_xbar,
  input  logic                   rst_xbar,
  input  logic                   i_wr_req,
  input  mem_req_t               i_wr_mem,
  output logic                   o_wr_gnt,
  input  logic                   i_rd_req,
  input  mem_req_t               i_rd_mem,
  output logic                   o_rd_gnt,
  output logic [`XBI_WORD_W-1:0] o_rd_data
);

  localparam int DEPTH = 1 << `XBI_ADR_W;

  logic [`XBI_WORD_W-1:0] mem_q [DEPTH];
  logic                   last_wr_q;
  logic                   acc_vld;
  mem_req_t               acc;

  // ====================================================================
  // Grant
  // ====================================================================
  always_comb begin
    o_wr_gnt = 1'b0;
    o_rd_gnt = 1'b0;
    if (i_wr_req && i_rd_req) begin
      // Favor whoever lost the previous grant
      o_wr_gnt = !last_wr_q;
      o_rd_gnt = last_wr_q;
    end else begin
      o_wr_gnt = i_wr_req;
      o_rd_gnt = i_rd_req;
    end
  end

  assign acc_vld = o_wr_gnt | o_rd_gnt;
  assign acc     = o_wr_gnt ? i_wr_mem : i_rd_mem;

  always_ff @(posedge clk_xbar) begin
    if (rst_xbar) begin
      last_wr_q <= 1'b0;
    end else if (acc_vld) begin
      last_wr_q <= o_wr_gnt;
    end
  end

  // ====================================================================
  // Buffer array
  // ====================================================================
  always_ff @(posedge clk_xbar) begin
    if (acc_vld && acc.op == MEM_WR) begin
      mem_q[acc.adr] <= acc.wdata;
    end
    // Read data shows up the cycle after the grant
    if (acc_vld && acc.op == MEM_RD) begin
      o_rd_data <= mem_q[acc.adr];
    end
  end

endmodule

// ==== hdl/xbi_usr_writer.sv ====
// ======================================================================
// User-side four-phase write port into the packet buffer
// Writes each word at its VC write base plus offset, then acknowledges
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module xbi_usr_writer
  import xbi_port_pkg::*;
  import xbi_mem_pkg::*;
(
  input  logic      clk_xbar,
  input  logic      rst_xbar,
  input  logic      i_usr_req,
  input  usr_word_t i_usr_word,
  output logic      o_usr_ack,
  input  vc_bases_t i_wr_bases,
  output logic      o_mem_req,
  output mem_req_t  o_mem,
  input  logic      i_mem_gnt,
  output vc_mask_t  o_wr_advance
);

  typedef enum logic [1:0] {
    IDLE,
    WRITE,
    ACK
  } state_e;

  state_e state_q;
  state_e state_d;
  adr_t   wr_adr;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (i_usr_req) state_d = WRITE;
      // Hold the request until the arbiter lets it through
      WRITE:   if (i_mem_gnt) state_d = ACK;
      ACK:     if (!i_usr_req) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_xbar) begin
    if (rst_xbar) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Word stays stable while the user holds its request
  assign wr_adr    = i_wr_bases[i_usr_word.vc] + adr_t'(i_usr_word.offset);
  assign o_mem     = '{op: MEM_WR, adr: wr_adr, wdata: i_usr_word.data};
  assign o_mem_req = (state_q == WRITE);
  assign o_usr_ack = (state_q == ACK);

  // Slot is complete once its last word lands
  always_comb begin
    o_wr_advance = '0;
    if (state_q == WRITE && i_mem_gnt && i_usr_word.eop) begin
      o_wr_advance = vc_mask_t'(1) << i_usr_word.vc;
    end
  end

endmodule

// ==== hdl/xbi_xbar_reader.sv ====
// ======================================================================
// Crossbar-side four-phase dequeue port with eager destination peek
// Idle cycles are spent reading offset 1 of a round-robin head packet
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module xbi_xbar_reader
  import xbi_port_pkg::*;
  import xbi_mem_pkg::*;
(
  input  logic                   clk_xbar,
  input  logic                   rst_xbar,
  input  logic                   i_xbar_req,
  input  xbar_deq_t              i_xbar_deq,
  output logic                   o_xbar_ack,
  output logic [`XBI_WORD_W-1:0] o_xbar_data,
  output peek_t                  o_xbar_peek,
  input  vc_bases_t              i_rd_bases,
  input  vc_mask_t               i_empty,
  output logic                   o_mem_req,
  output mem_req_t               o_mem,
  input  logic                   i_mem_gnt,
  input  logic [`XBI_WORD_W-1:0] i_mem_data,
  output vc_mask_t               o_rd_advance
);

  typedef enum logic [2:0] {
    IDLE,
    PEEK_RD,
    PEEK_WAIT,
    DEQ_RD,
    DEQ_WAIT,
    ACK
  } state_e;

  state_e state_q;
  state_e state_d;
  vc_e    rr_q;
  vc_e    next_vc;
  logic   any_pkt;

  assign any_pkt = !(&i_empty);

  // Next non-empty VC after rr_q with rr_q itself checked last
  always_comb begin
    int unsigned cand;
    next_vc = rr_q;
    for (int k = `XBI_NUM_VC; k >= 1; k--) begin
      cand = (int'(rr_q) + k) % `XBI_NUM_VC;
      if (!i_empty[cand]) next_vc = vc_e'(cand);
    end
  end

  // ====================================================================
  // FSM with dequeue taking priority over peek
  // ====================================================================
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      IDLE: begin
        if (i_xbar_req) state_d = DEQ_RD;
        else if (any_pkt) state_d = PEEK_RD;
      end
      PEEK_RD: begin
        if (i_mem_gnt) state_d = PEEK_WAIT;
        else if (i_xbar_req) state_d = DEQ_RD;
      end
      PEEK_WAIT: state_d = i_xbar_req ? DEQ_RD : IDLE;
      DEQ_RD:    if (i_mem_gnt) state_d = DEQ_WAIT;
      DEQ_WAIT:  state_d = ACK;
      ACK:       if (!i_xbar_req) state_d = IDLE;
      default:   state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_xbar) begin
    if (rst_xbar) begin
      state_q     <= IDLE;
      rr_q        <= VC2;
      o_xbar_peek <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && !i_xbar_req && any_pkt) begin
        rr_q <= next_vc;
      end
      if (state_q == PEEK_WAIT) begin
        o_xbar_peek <= '{valid: 1'b1, vc: rr_q, dst: i_mem_data};
      end else if (o_xbar_peek.valid && i_empty[o_xbar_peek.vc]) begin
        o_xbar_peek.valid <= 1'b0;
      end
    end
  end

  // Dequeued word held for the whole ack phase
  always_ff @(posedge clk_xbar) begin
    if (state_q == DEQ_WAIT) begin
      o_xbar_data <= i_mem_data;
    end
  end

  // ====================================================================
  // Buffer request
  // ====================================================================
  always_comb begin
    o_mem.op    = MEM_RD;
    o_mem.wdata = '0;
    if (state_q == DEQ_RD) begin
      o_mem.adr = i_rd_bases[i_xbar_deq.vc] + adr_t'(i_xbar_deq.offset);
    end else begin
      o_mem.adr = i_rd_bases[rr_q] + adr_t'(`XBI_DST_OFS);
    end
  end

  assign o_mem_req  = (state_q == DEQ_RD) || (state_q == PEEK_RD);
  assign o_xbar_ack = (state_q == ACK);

  always_comb begin
    o_rd_advance = '0;
    if (state_q == DEQ_RD && i_mem_gnt && i_xbar_deq.eop) begin
      o_rd_advance = vc_mask_t'(1) << i_xbar_deq.vc;
    end
  end

endmodule

// ==== hdl/xbi_top.sv ====
// ======================================================================
// User-to-crossbar network interface top level
// Connects writer, reader, buffer arbiter and per-VC slot pointers
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module xbi_top
  import xbi_port_pkg::*;
  import xbi_mem_pkg::*;
(
  input  logic                   clk_xbar,
  input  logic                   rst_xbar,
  // User port
  input  logic                   i_usr_req,
  input  usr_word_t              i_usr_word,
  output logic                   o_usr_ack,
  output vc_mask_t               o_usr_full,
  // Crossbar port
  input  logic                   i_xbar_req,
  input  xbar_deq_t              i_xbar_deq,
  output logic                   o_xbar_ack,
  output logic [`XBI_WORD_W-1:0] o_xbar_data,
  output vc_mask_t               o_xbar_empty,
  output peek_t                  o_xbar_peek
);

  logic                   wr_mem_req;
  mem_req_t               wr_mem;
  logic                   wr_gnt;
  logic                   rd_mem_req;
  mem_req_t               rd_mem;
  logic                   rd_gnt;
  logic [`XBI_WORD_W-1:0] rd_data;
  vc_bases_t              wr_bases;
  vc_bases_t              rd_bases;
  vc_mask_t               wr_adv;
  vc_mask_t               rd_adv;

  xbi_usr_writer xbi_usr_writer_i (
    .clk_xbar     (clk_xbar),
    .rst_xbar     (rst_xbar),
    .i_usr_req    (i_usr_req),
    .i_usr_word   (i_usr_word),
    .o_usr_ack    (o_usr_ack),
    .i_wr_bases   (wr_bases),
    .o_mem_req    (wr_mem_req),
    .o_mem        (wr_mem),
    .i_mem_gnt    (wr_gnt),
    .o_wr_advance (wr_adv)
  );

  xbi_xbar_reader xbi_xbar_reader_i (
    .clk_xbar     (clk_xbar),
    .rst_xbar     (rst_xbar),
    .i_xbar_req   (i_xbar_req),
    .i_xbar_deq   (i_xbar_deq),
    .o_xbar_ack   (o_xbar_ack),
    .o_xbar_data  (o_xbar_data),
    .o_xbar_peek  (o_xbar_peek),
    .i_rd_bases   (rd_bases),
    .i_empty      (o_xbar_empty),
    .o_mem_req    (rd_mem_req),
    .o_mem        (rd_mem),
    .i_mem_gnt    (rd_gnt),
    .i_mem_data   (rd_data),
    .o_rd_advance (rd_adv)
  );

  xbi_mem_arbiter xbi_mem_arbiter_i (
    .clk_xbar  (clk_xbar),
    .rst_xbar  (rst_xbar),
    .i_wr_req  (wr_mem_req),
    .i_wr_mem  (wr_mem),
    .o_wr_gnt  (wr_gnt),
    .i_rd_req  (rd_mem_req),
    .i_rd_mem  (rd_mem),
    .o_rd_gnt  (rd_gnt),
    .o_rd_data (rd_data)
  );

  // One slot ring per VC
  for (genvar g = 0; g < `XBI_NUM_VC; g++) begin : g_slot_ptr
    xbi_slot_ptr #(
      .BASE_START  ((g == 0) ? adr_t'(`XBI_VC0_BASE) :
                    (g == 1) ? adr_t'(`XBI_VC1_BASE) : adr_t'(`XBI_VC2_BASE)),
      .PACKET_SIZE ((g == 0) ? adr_t'(`XBI_VC0_PKT) :
                    (g == 1) ? adr_t'(`XBI_VC1_PKT) : adr_t'(`XBI_VC2_PKT))
    ) xbi_slot_ptr_i (
      .clk_xbar     (clk_xbar),
      .rst_xbar     (rst_xbar),
      .i_wr_advance (wr_adv[g]),
      .i_rd_advance (rd_adv[g]),
      .o_full       (o_usr_full[g]),
      .o_empty      (o_xbar_empty[g]),
      .o_wr_base    (wr_bases[g]),
      .o_rd_base    (rd_bases[g])
    );
  end

endmodule

// ==== test/tb_xbi.sv ====
// ======================================================================
// Testbench for the user-to-crossbar network interface
// Steps through a table of write and dequeue rows, checking data,
// full and empty masks and the destination peek against a queue model
// ======================================================================

`timescale 1ns/1ps
`include "xbi_macros.svh"

module tb_xbi
  import xbi_port_pkg::*;
;

  localparam int          NUM_STEPS  = 7;
  localparam int          HS_LIMIT   = 16;
  localparam int          PEEK_LIMIT = 16;
  localparam int          OFS_W      = `XBI_OFS_W;
  localparam logic [31:0] SEED       = 32'he17a1077;

  // Each row holds target VC, packets to write, words each and packets to read back
  typedef struct packed {
    vc_e vc;
    int  npkt;
    int  nwords;
    int  nread;
  } step_t;

  logic                   clk_xbar;
  logic                   rst_xbar;
  logic                   i_usr_req;
  usr_word_t              i_usr_word;
  logic                   o_usr_ack;
  vc_mask_t               o_usr_full;
  logic                   i_xbar_req;
  xbar_deq_t              i_xbar_deq;
  logic                   o_xbar_ack;
  logic [`XBI_WORD_W-1:0] o_xbar_data;
  vc_mask_t               o_xbar_empty;
  peek_t                  o_xbar_peek;

  step_t                  steps [NUM_STEPS];
  logic [`XBI_WORD_W-1:0] ref_q [`XBI_NUM_VC][$];
  int                     len_q [`XBI_NUM_VC][$];
  int                     pkt_cnt [`XBI_NUM_VC];

  xbi_top xbi_top_i (
    .clk_xbar     (clk_xbar),
    .rst_xbar     (rst_xbar),
    .i_usr_req    (i_usr_req),
    .i_usr_word   (i_usr_word),
    .o_usr_ack    (o_usr_ack),
    .o_usr_full   (o_usr_full),
    .i_xbar_req   (i_xbar_req),
    .i_xbar_deq   (i_xbar_deq),
    .o_xbar_ack   (o_xbar_ack),
    .o_xbar_data  (o_xbar_data),
    .o_xbar_empty (o_xbar_empty),
    .o_xbar_peek  (o_xbar_peek)
  );

  always #20 clk_xbar = ~clk_xbar;

  // ====================================================================
  // Compare tasks
  // ====================================================================
  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_mask(input string name, input vc_mask_t got, input vc_mask_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input logic [`XBI_WORD_W-1:0] got,
                            input logic [`XBI_WORD_W-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got 0x%04h, expected 0x%04h", name, got, exp));
    end
  endtask

  task automatic check_peek(input string name, input peek_t got, input peek_t exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got 0x%05h, expected 0x%05h", name, got, exp));
    end
  endtask

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Masks expected from the packet counts of the model
  task automatic check_flags();
    vc_mask_t exp_full;
    vc_mask_t exp_empty;
    for (int v = 0; v < `XBI_NUM_VC; v++) begin
      exp_full[v]  = (pkt_cnt[v] == `XBI_SLOTS);
      exp_empty[v] = (pkt_cnt[v] == 0);
    end
    check_mask("o_usr_full", o_usr_full, exp_full);
    check_mask("o_xbar_empty", o_xbar_empty, exp_empty);
  endtask

  // ====================================================================
  // Four-phase handshakes
  // ====================================================================
  task automatic wait_ack(input bit xbar_side, input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk_xbar);
    while ((xbar_side ? o_xbar_ack : o_usr_ack) !== level) begin
      if (n == HS_LIMIT) begin
        stop_on_error($sformatf("Handshake timeout: %s never went to %0b", what, level));
      end
      n++;
      @(negedge clk_xbar);
    end
  endtask

  task automatic usr_write(input usr_word_t w);
    @(posedge clk_xbar);
    i_usr_word <= w;
    i_usr_req  <= 1'b1;
    wait_ack(1'b0, 1'b1, "o_usr_ack");
    @(posedge clk_xbar);
    i_usr_req <= 1'b0;
    wait_ack(1'b0, 1'b0, "o_usr_ack");
  endtask

  task automatic xbar_dequeue(input xbar_deq_t d, input logic [`XBI_WORD_W-1:0] exp);
    @(posedge clk_xbar);
    i_xbar_deq <= d;
    i_xbar_req <= 1'b1;
    wait_ack(1'b1, 1'b1, "o_xbar_ack");
    check_word("o_xbar_data", o_xbar_data, exp);
    @(posedge clk_xbar);
    i_xbar_req <= 1'b0;
    wait_ack(1'b1, 1'b0, "o_xbar_ack");
  endtask

  // ====================================================================
  // Packet level steps
  // ====================================================================
  task automatic write_pkt(input vc_e vc, input int nwords);
    logic [`XBI_WORD_W-1:0] d;
    for (int k = 0; k < nwords; k++) begin
      d = `XBI_WORD_W'($urandom);
      ref_q[vc].push_back(d);
      usr_write('{vc: vc, offset: OFS_W'(k), eop: (k == nwords - 1), data: d});
    end
    len_q[vc].push_back(nwords);
    pkt_cnt[vc]++;
    check_flags();
  endtask

  task automatic read_pkt(input vc_e vc);
    int len;
    len = len_q[vc].pop_front();
    for (int k = 0; k < len; k++) begin
      xbar_dequeue('{vc: vc, offset: OFS_W'(k), eop: (k == len - 1)}, ref_q[vc].pop_front());
    end
    pkt_cnt[vc]--;
    check_flags();
  endtask

  // Peek should settle on the head packet's destination word
  task automatic poll_peek(input vc_e vc);
    peek_t exp;
    int    n;
    exp = '{valid: 1'b1, vc: vc, dst: ref_q[vc][`XBI_DST_OFS]};
    n = 0;
    while (o_xbar_peek !== exp && n < PEEK_LIMIT) begin
      n++;
      @(negedge clk_xbar);
    end
    check_peek("o_xbar_peek", o_xbar_peek, exp);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial begin
    int total_words;
    int nonempty;
    clk_xbar   = 1'b0;
    rst_xbar   = 1'b1;
    i_usr_req  = 1'b0;
    i_usr_word = '0;
    i_xbar_req = 1'b0;
    i_xbar_deq = '0;
    void'($urandom(SEED));

    steps[0] = '{VC1, 1, 5, 1};
    steps[1] = '{VC0, 6, 12, 0};
    steps[2] = '{VC2, 1, 3, 0};
    steps[3] = '{VC0, 0, 12, 6};
    steps[4] = '{VC2, 0, 3, 1};
    // Two rounds of four packets take VC2 around its ring
    steps[5] = '{VC2, 4, 64, 4};
    steps[6] = '{VC2, 4, 64, 4};

    total_words = 0;
    for (int r = 0; r < NUM_STEPS; r++) begin
      total_words += steps[r].npkt * steps[r].nwords;
    end
    for (int v = 0; v < `XBI_NUM_VC; v++) begin
      pkt_cnt[v] = 0;
    end

    // Each word is written once and read once at about 20 cycles a handshake
    fork
      begin
        repeat (100 + NUM_STEPS * PEEK_LIMIT + 2 * total_words * 20) @(posedge clk_xbar);
        $display("Watchdog expired before the test sequence finished");
        $display("Some tests failed");
        $fatal(1);
      end
    join_none

    repeat (8) @(posedge clk_xbar);
    rst_xbar <= 1'b0;
    @(negedge clk_xbar);
    check_flags();
    check_level("o_usr_ack", o_usr_ack, 1'b0);
    check_level("o_xbar_ack", o_xbar_ack, 1'b0);
    check_level("o_xbar_peek.valid", o_xbar_peek.valid, 1'b0);

    for (int r = 0; r < NUM_STEPS; r++) begin
      for (int p = 0; p < steps[r].npkt; p++) begin
        write_pkt(steps[r].vc, steps[r].nwords);
      end
      nonempty = 0;
      for (int v = 0; v < `XBI_NUM_VC; v++) begin
        nonempty += (pkt_cnt[v] != 0) ? 1 : 0;
      end
      if (steps[r].npkt > 0 && nonempty == 1 && len_q[steps[r].vc][0] > `XBI_DST_OFS) begin
        poll_peek(steps[r].vc);
      end
      for (int p = 0; p < steps[r].nread; p++) begin
        read_pkt(steps[r].vc);
      end
    end

    $display("All tests passed");
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hdl
hdl/xbi_port_pkg.sv
hdl/xbi_mem_pkg.sv
hdl/xbi_slot_ptr.sv
hdl/xbi_mem_arbiter.sv
hdl/xbi_usr_writer.sv
hdl/xbi_xbar_reader.sv
hdl/xbi_top.sv
test/tb_xbi.sv

// ==== Makefile ====
# Verilator build and run for the crossbar interface testbench

VERILATOR ?= verilator
TOP       ?= tb_xbi
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
LINTFLAGS ?= --lint-only --timing
FAIL_MSG  ?= Some tests failed
PASS_MSG  ?= All tests passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
